//--- design/soc_pkg.sv
package soc_pkg;

	// Bus widths
	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 32;
	localparam int SEL_W      = DATA_W / 8;	// One select per byte lane

	// CSR word address, bank in 13..10, register in 9..0
	localparam int CSR_ADDR_W = 14;

	// System controller pins
	localparam int GPIO_OUT_W = 4;	// LEDs
	localparam int GPIO_IN_W  = 2;
	localparam int PWM_W      = 8;	// Backlight PWM, period 256

	localparam logic [DATA_W-1:0] SYSTEM_ID = 32'h50c0_a001;

	// Region field, address bits 30..28; bit 31 is a shadow
	typedef enum logic [2:0] {
		REGION_RAM = 3'd0,
		REGION_CSR = 3'd3
	} region_e;

	// Register index inside the sysctl bank
	typedef enum logic [9:0] {
		REG_GPIO_OUT      = 10'd0,
		REG_GPIO_IN       = 10'd1,
		REG_TIMER_CTRL    = 10'd2,	// En, autoreload, expired
		REG_TIMER_COMPARE = 10'd3,
		REG_TIMER_COUNT   = 10'd4,
		REG_PWM_DUTY      = 10'd5,
		REG_SYSTEM_ID     = 10'd6,
		REG_RESET         = 10'd7
	} sysctl_reg_e;

endpackage

//--- design/reset_seq.sv
`timescale 1ns/1ps

module reset_seq #(
	parameter int RESET_CYCLES = 32
) (
	input  logic sys_clk,
	input  logic hard_reset,
	input  logic soft_reset_req_i,	// One-cycle pulse from sysctl
	output logic sys_rst_o
);

	localparam int CNT_W = $clog2(RESET_CYCLES + 1);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;
	logic             rst_q;

	// Reload on soft request, else count down to zero
	always_comb begin
		cnt_next = cnt;
		if (soft_reset_req_i)
			cnt_next = CNT_W'(RESET_CYCLES);
		else if (cnt != '0)
			cnt_next = cnt - 1'b1;
	end

	// Reset output registered so downstream async resets see no decode glitch
	always_ff @(posedge sys_clk or posedge hard_reset) begin
		if (hard_reset) begin
			cnt   <= CNT_W'(RESET_CYCLES);
			rst_q <= 1'b1;
		end else begin
			cnt   <= cnt_next;
			rst_q <= cnt_next != '0;	// Falls with the last count
		end
	end

	assign sys_rst_o = rst_q;

endmodule

//--- design/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
	input  logic                      sys_clk,
	input  logic                      sys_rst_i,
	// External master
	input  logic                      bus_cyc_i,
	input  logic                      bus_stb_i,
	input  logic [soc_pkg::ADDR_W-1:0] bus_adr_i,
	output logic [soc_pkg::DATA_W-1:0] bus_dat_o,
	output logic                      bus_ack_o,
	// Scratch RAM slave
	output logic                      ram_stb_o,
	input  logic [soc_pkg::DATA_W-1:0] ram_dat_i,
	input  logic                      ram_ack_i,
	// CSR bridge slave
	output logic                      csr_stb_o,
	input  logic [soc_pkg::DATA_W-1:0] brg_dat_i,
	input  logic                      brg_ack_i
);

	soc_pkg::region_e region;
	logic             access;
	logic             unmapped;
	logic             nack;	// Ack for accesses that hit no slave

	// Bit 31 ignored, shadow mapping as on the board
	assign region = soc_pkg::region_e'(bus_adr_i[30:28]);
	assign access = bus_cyc_i & bus_stb_i;

	assign ram_stb_o = access && (region == soc_pkg::REGION_RAM);
	assign csr_stb_o = access && (region == soc_pkg::REGION_CSR);
	assign unmapped  = access && !ram_stb_o && !csr_stb_o;

	// One-cycle answer, never back to back
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i)
			nack <= 1'b0;
		else
			nack <= unmapped & ~nack;
	end

	assign bus_ack_o = ram_ack_i | brg_ack_i | nack;

	// Return data of whichever slave acks, zero otherwise
	always_comb begin
		if (ram_ack_i)
			bus_dat_o = ram_dat_i;
		else if (brg_ack_i)
			bus_dat_o = brg_dat_i;
		else
			bus_dat_o = '0;	// Unmapped read or idle
	end

endmodule

//--- design/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
	parameter int RAM_WORDS = 256	// Power of two
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst_i,
	input  logic                      stb_i,
	input  logic                      we_i,
	input  logic [soc_pkg::ADDR_W-1:0] adr_i,
	input  logic [soc_pkg::SEL_W-1:0]  sel_i,
	input  logic [soc_pkg::DATA_W-1:0] dat_i,
	output logic [soc_pkg::DATA_W-1:0] dat_o,
	output logic                      ack_o
);

	localparam int IDX_W = $clog2(RAM_WORDS);

	logic [soc_pkg::DATA_W-1:0] mem [RAM_WORDS];
	logic [IDX_W-1:0]           idx;
	logic                       access;

	// Word index above the byte offset, upper bits alias
	assign idx    = adr_i[IDX_W+1:2];
	assign access = stb_i & ~ack_o;	// Strobe is still up in the ack cycle

	// Array and read data
	always_ff @(posedge sys_clk) begin
		if (access) begin
			if (we_i) begin
				for (int b = 0; b < soc_pkg::SEL_W; b++) begin
					if (sel_i[b])
						mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
				end
			end
			dat_o <= mem[idx];	// Old word on a write
		end
	end

	// Single-cycle acknowledge
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i)
			ack_o <= 1'b0;
		else
			ack_o <= access;
	end

endmodule

//--- design/csr_bridge.sv
`timescale 1ns/1ps

module csr_bridge (
	input  logic                          sys_clk,
	input  logic                          sys_rst_i,
	// Bus side
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [soc_pkg::ADDR_W-1:0]     adr_i,
	input  logic [soc_pkg::DATA_W-1:0]     dat_i,
	output logic [soc_pkg::DATA_W-1:0]     dat_o,
	output logic                          ack_o,
	// CSR side
	output logic [soc_pkg::CSR_ADDR_W-1:0] csr_a_o,
	output logic                          csr_we_o,
	output logic [soc_pkg::DATA_W-1:0]     csr_dw_o,
	input  logic [soc_pkg::DATA_W-1:0]     csr_dr_i
);

	typedef enum logic {
		BRG_IDLE,	// Waiting for a strobe
		BRG_WAIT	// CSR read data on its way
	} brg_state_e;

	brg_state_e state;
	logic       start;

	// New access only outside the ack cycle
	assign start = (state == BRG_IDLE) && stb_i && !ack_o;

	// Word address, byte selects unused
	assign csr_a_o  = adr_i[soc_pkg::CSR_ADDR_W+1:2];
	assign csr_dw_o = dat_i;
	assign csr_we_o = start & we_i;	// Single pulse per access

	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			state <= BRG_IDLE;
			ack_o <= 1'b0;
		end else begin
			case (state)
				BRG_IDLE: begin
					ack_o <= 1'b0;
					if (start)
						state <= BRG_WAIT;
				end
				BRG_WAIT: begin
					ack_o <= 1'b1;	// Registered csr_dr valid now
					state <= BRG_IDLE;
				end
				default: state <= BRG_IDLE;
			endcase
		end
	end

	// Capture read data with the ack
	always_ff @(posedge sys_clk) begin
		if (state == BRG_WAIT)
			dat_o <= csr_dr_i;
	end

endmodule

//--- design/sysctl_regs.sv
`timescale 1ns/1ps

module sysctl_regs #(
	parameter int SYSCTL_BANK = 1
) (
	input  logic                          sys_clk,
	input  logic                          sys_rst_i,
	// CSR bus
	input  logic [soc_pkg::CSR_ADDR_W-1:0] csr_a_i,
	input  logic                          csr_we_i,
	input  logic [soc_pkg::DATA_W-1:0]     csr_dw_i,
	output logic [soc_pkg::DATA_W-1:0]     csr_dr_o,
	// GPIO
	input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] leds_o,
	// Timer and PWM control
	output logic                          timer_en_o,
	output logic                          timer_autoreload_o,
	output logic [soc_pkg::DATA_W-1:0]     timer_compare_o,
	output logic                          timer_irq_clear_o,
	output logic [soc_pkg::PWM_W-1:0]      pwm_duty_o,
	input  logic [soc_pkg::DATA_W-1:0]     timer_count_i,
	input  logic                          timer_expired_i,
	input  logic                          timer_done_i,	// Single shot finished
	// Reset sequencer
	output logic                          soft_reset_req_o
);

	localparam int BANK_W = soc_pkg::CSR_ADDR_W - 10;

	logic                         bank_hit;
	logic                         wr;
	soc_pkg::sysctl_reg_e         reg_idx;
	logic [soc_pkg::GPIO_IN_W-1:0] gpio_meta;
	logic [soc_pkg::GPIO_IN_W-1:0] gpio_q;
	logic                         reset_pend;

	assign bank_hit = csr_a_i[soc_pkg::CSR_ADDR_W-1:10] == BANK_W'(SYSCTL_BANK);
	assign reg_idx  = soc_pkg::sysctl_reg_e'(csr_a_i[9:0]);
	assign wr       = csr_we_i & bank_hit;

	// Pads are asynchronous
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			gpio_meta <= '0;
			gpio_q    <= '0;
		end else begin
			gpio_meta <= gpio_i;
			gpio_q    <= gpio_meta;
		end
	end

	// Writable registers and pulses
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			leds_o             <= '0;
			timer_en_o         <= 1'b0;
			timer_autoreload_o <= 1'b0;
			timer_compare_o    <= '0;
			timer_irq_clear_o  <= 1'b0;
			pwm_duty_o         <= '0;
			reset_pend         <= 1'b0;
			soft_reset_req_o   <= 1'b0;
		end else begin
			timer_irq_clear_o <= 1'b0;
			reset_pend        <= 1'b0;
			soft_reset_req_o  <= reset_pend;	// Lands after the bridge ack
			if (timer_done_i)
				timer_en_o <= 1'b0;	// Write below wins
			if (wr) begin
				case (reg_idx)
					soc_pkg::REG_GPIO_OUT:      leds_o <= csr_dw_i[soc_pkg::GPIO_OUT_W-1:0];
					soc_pkg::REG_TIMER_CTRL: begin
						timer_en_o         <= csr_dw_i[0];
						timer_autoreload_o <= csr_dw_i[1];
						timer_irq_clear_o  <= csr_dw_i[2];	// Clear expired
					end
					soc_pkg::REG_TIMER_COMPARE: timer_compare_o <= csr_dw_i;
					soc_pkg::REG_PWM_DUTY:      pwm_duty_o <= csr_dw_i[soc_pkg::PWM_W-1:0];
					soc_pkg::REG_RESET:         reset_pend <= csr_dw_i[0];
					default: ;	// Read-only or unused
				endcase
			end
		end
	end

	// Registered read data, zero outside the bank
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i)
			csr_dr_o <= '0;
		else if (!bank_hit)
			csr_dr_o <= '0;
		else begin
			case (reg_idx)
				soc_pkg::REG_GPIO_OUT:      csr_dr_o <= soc_pkg::DATA_W'(leds_o);
				soc_pkg::REG_GPIO_IN:       csr_dr_o <= soc_pkg::DATA_W'(gpio_q);
				soc_pkg::REG_TIMER_CTRL:
					csr_dr_o <= {29'd0, timer_expired_i, timer_autoreload_o, timer_en_o};
				soc_pkg::REG_TIMER_COMPARE: csr_dr_o <= timer_compare_o;
				soc_pkg::REG_TIMER_COUNT:   csr_dr_o <= timer_count_i;
				soc_pkg::REG_PWM_DUTY:      csr_dr_o <= soc_pkg::DATA_W'(pwm_duty_o);
				soc_pkg::REG_SYSTEM_ID:     csr_dr_o <= soc_pkg::SYSTEM_ID;
				default:                    csr_dr_o <= '0;	// Reset reg reads zero
			endcase
		end
	end

endmodule

//--- design/sysctl_timer.sv
`timescale 1ns/1ps

module sysctl_timer (
	input  logic                      sys_clk,
	input  logic                      sys_rst_i,
	input  logic                      timer_en_i,
	input  logic                      timer_autoreload_i,
	input  logic [soc_pkg::DATA_W-1:0] timer_compare_i,
	input  logic                      timer_irq_clear_i,
	input  logic [soc_pkg::PWM_W-1:0]  pwm_duty_i,
	output logic [soc_pkg::DATA_W-1:0] timer_count_o,
	output logic                      timer_expired_o,
	output logic                      timer_done_o,
	output logic                      pwm_o
);

	logic                     timer_match;
	logic [soc_pkg::PWM_W-1:0] pwm_cnt;

	assign timer_match  = timer_en_i && (timer_count_o == timer_compare_i);
	assign timer_done_o = timer_match & ~timer_autoreload_i;	// Drops enable in regs

	// Interval counter, back to zero on match
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i)
			timer_count_o <= '0;
		else if (timer_match)
			timer_count_o <= '0;
		else if (timer_en_i)
			timer_count_o <= timer_count_o + 1'b1;
	end

	// Sticky expired flag, also the interrupt
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i)
			timer_expired_o <= 1'b0;
		else if (timer_match)
			timer_expired_o <= 1'b1;	// Set beats clear
		else if (timer_irq_clear_i)
			timer_expired_o <= 1'b0;
	end

	// Free-running PWM, period 256
	always_ff @(posedge sys_clk or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			pwm_cnt <= '0;
			pwm_o   <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			pwm_o   <= pwm_cnt < pwm_duty_i;	// Duty cycles high per period
		end
	end

endmodule

//--- design/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
	parameter int RESET_CYCLES = 32,
	parameter int RAM_WORDS    = 256,
	parameter int SYSCTL_BANK  = 1
) (
	input  logic                          sys_clk,
	input  logic                          hard_reset,
	// External bus master
	input  logic                          bus_cyc_i,
	input  logic                          bus_stb_i,
	input  logic                          bus_we_i,
	input  logic [soc_pkg::ADDR_W-1:0]     bus_adr_i,
	input  logic [soc_pkg::SEL_W-1:0]      bus_sel_i,
	input  logic [soc_pkg::DATA_W-1:0]     bus_dat_i,
	output logic [soc_pkg::DATA_W-1:0]     bus_dat_o,
	output logic                          bus_ack_o,
	// Board pins
	input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] leds_o,
	output logic                          pwm_o,	// Backlight
	output logic                          irq_o,
	output logic                          sys_rst_o	// Also holds board parts
);

	// Slave links
	logic                          ram_stb;
	logic [soc_pkg::DATA_W-1:0]     ram_dat;
	logic                          ram_ack;
	logic                          csr_stb;
	logic [soc_pkg::DATA_W-1:0]     brg_dat;
	logic                          brg_ack;

	// CSR bus
	logic [soc_pkg::CSR_ADDR_W-1:0] csr_a;
	logic                          csr_we;
	logic [soc_pkg::DATA_W-1:0]     csr_dw;
	logic [soc_pkg::DATA_W-1:0]     csr_dr;

	// Sysctl to timer
	logic                          timer_en;
	logic                          timer_autoreload;
	logic [soc_pkg::DATA_W-1:0]     timer_compare;
	logic                          timer_irq_clear;
	logic [soc_pkg::PWM_W-1:0]      pwm_duty;
	logic [soc_pkg::DATA_W-1:0]     timer_count;
	logic                          timer_expired;
	logic                          timer_done;
	logic                          soft_reset_req;

	reset_seq #(
		.RESET_CYCLES(RESET_CYCLES)
	) i_reset_seq (
		.sys_clk         (sys_clk),
		.hard_reset      (hard_reset),
		.soft_reset_req_i(soft_reset_req),
		.sys_rst_o       (sys_rst_o)
	);

	bus_decode i_bus_decode (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst_o),
		.bus_cyc_i(bus_cyc_i),
		.bus_stb_i(bus_stb_i),
		.bus_adr_i(bus_adr_i),
		.bus_dat_o(bus_dat_o),
		.bus_ack_o(bus_ack_o),
		.ram_stb_o(ram_stb),
		.ram_dat_i(ram_dat),
		.ram_ack_i(ram_ack),
		.csr_stb_o(csr_stb),
		.brg_dat_i(brg_dat),
		.brg_ack_i(brg_ack)
	);

	// Address, write, select and data shared by both slaves
	scratch_ram #(
		.RAM_WORDS(RAM_WORDS)
	) i_scratch_ram (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst_o),
		.stb_i    (ram_stb),
		.we_i     (bus_we_i),
		.adr_i    (bus_adr_i),
		.sel_i    (bus_sel_i),
		.dat_i    (bus_dat_i),
		.dat_o    (ram_dat),
		.ack_o    (ram_ack)
	);

	csr_bridge i_csr_bridge (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst_o),
		.stb_i    (csr_stb),
		.we_i     (bus_we_i),
		.adr_i    (bus_adr_i),
		.dat_i    (bus_dat_i),
		.dat_o    (brg_dat),
		.ack_o    (brg_ack),
		.csr_a_o  (csr_a),
		.csr_we_o (csr_we),
		.csr_dw_o (csr_dw),
		.csr_dr_i (csr_dr)	// Only bank on the CSR bus
	);

	sysctl_regs #(
		.SYSCTL_BANK(SYSCTL_BANK)
	) i_sysctl_regs (
		.sys_clk           (sys_clk),
		.sys_rst_i         (sys_rst_o),
		.csr_a_i           (csr_a),
		.csr_we_i          (csr_we),
		.csr_dw_i          (csr_dw),
		.csr_dr_o          (csr_dr),
		.gpio_i            (gpio_i),
		.leds_o            (leds_o),
		.timer_en_o        (timer_en),
		.timer_autoreload_o(timer_autoreload),
		.timer_compare_o   (timer_compare),
		.timer_irq_clear_o (timer_irq_clear),
		.pwm_duty_o        (pwm_duty),
		.timer_count_i     (timer_count),
		.timer_expired_i   (timer_expired),
		.timer_done_i      (timer_done),
		.soft_reset_req_o  (soft_reset_req)
	);

	sysctl_timer i_sysctl_timer (
		.sys_clk           (sys_clk),
		.sys_rst_i         (sys_rst_o),
		.timer_en_i        (timer_en),
		.timer_autoreload_i(timer_autoreload),
		.timer_compare_i   (timer_compare),
		.timer_irq_clear_i (timer_irq_clear),
		.pwm_duty_i        (pwm_duty),
		.timer_count_o     (timer_count),
		.timer_expired_o   (timer_expired),
		.timer_done_o      (timer_done),
		.pwm_o             (pwm_o)
	);

	assign irq_o = timer_expired;	// Level until cleared

endmodule

//--- test/soc_props.sv
`timescale 1ns/1ps

module soc_props (
	input logic sys_clk,
	input logic hard_reset,
	input logic sys_rst_i,
	input logic stb_i,	// Master strobe
	input logic ack_i,	// Top-level acknowledge
	input logic irq_i,
	input logic pwm_i
);

	// Ack is a single-cycle pulse
	ack_single: assert property (@(posedge sys_clk) disable iff (hard_reset)
		ack_i |=> !ack_i)
		else $error("Bus acknowledge high for two cycles in a row");

	// Outputs held quiet during system reset
	quiet_in_reset: assert property (@(posedge sys_clk)
		sys_rst_i |-> (!ack_i && !irq_i && !pwm_i))
		else $error("Acknowledge, interrupt or PWM active during system reset");

	// No ack without a strobe the cycle before
	ack_after_stb: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		ack_i |-> $past(stb_i))
		else $error("Bus acknowledge without a preceding strobe");

endmodule

bind soc_top soc_props i_soc_props (
	.sys_clk   (sys_clk),
	.hard_reset(hard_reset),
	.sys_rst_i (sys_rst_o),
	.stb_i     (bus_stb_i),
	.ack_i     (bus_ack_o),
	.irq_i     (irq_o),
	.pwm_i     (pwm_o)
);

//--- test/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

	localparam int RESET_CYCLES = 32;
	localparam int RAM_WORDS    = 256;
	localparam int SYSCTL_BANK  = 1;
	localparam int IDX_W        = $clog2(RAM_WORDS);
	localparam int BUS_GUARD    = 64;	// Cycles allowed per access
	localparam int MAX_CYCLES   = 20000;	// Summed test lengths with margin

	logic                          sys_clk;
	logic                          hard_reset;
	logic                          bus_cyc;
	logic                          bus_stb;
	logic                          bus_we;
	logic [soc_pkg::ADDR_W-1:0]     bus_adr;
	logic [soc_pkg::SEL_W-1:0]      bus_sel;
	logic [soc_pkg::DATA_W-1:0]     bus_dat_w;
	logic [soc_pkg::DATA_W-1:0]     bus_dat_r;
	logic                          bus_ack;
	logic [soc_pkg::GPIO_IN_W-1:0]  gpio;
	logic [soc_pkg::GPIO_OUT_W-1:0] leds;
	logic                          pwm;
	logic                          irq;
	logic                          sys_rst;

	logic [31:0] ram_model [RAM_WORDS];	// Expected RAM contents
	int          checks_ok;
	int          checks_bad;
	int          cycle_cnt = 0;

	soc_top #(
		.RESET_CYCLES(RESET_CYCLES),
		.RAM_WORDS   (RAM_WORDS),
		.SYSCTL_BANK (SYSCTL_BANK)
	) i_soc_top (
		.sys_clk  (sys_clk),
		.hard_reset(hard_reset),
		.bus_cyc_i(bus_cyc),
		.bus_stb_i(bus_stb),
		.bus_we_i (bus_we),
		.bus_adr_i(bus_adr),
		.bus_sel_i(bus_sel),
		.bus_dat_i(bus_dat_w),
		.bus_dat_o(bus_dat_r),
		.bus_ack_o(bus_ack),
		.gpio_i   (gpio),
		.leds_o   (leds),
		.pwm_o    (pwm),
		.irq_o    (irq),
		.sys_rst_o(sys_rst)
	);

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;	// 8 ns period

	// Hard stop for a stuck run
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			checks_bad++;
		end else
			checks_ok++;
	endtask

	// One bus cycle, held until ack, inputs changed on the falling edge
	task automatic access_bus(input logic we, input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int wait_cnt;
		wait_cnt = 0;
		rdat     = '0;
		@(negedge sys_clk);
		bus_cyc   = 1'b1;
		bus_stb   = 1'b1;
		bus_we    = we;
		bus_adr   = adr;
		bus_sel   = sel;
		bus_dat_w = wdat;
		@(negedge sys_clk);
		while (!bus_ack && wait_cnt < BUS_GUARD) begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		if (bus_ack)
			rdat = bus_dat_r;
		else begin
			$display("No acknowledge for address %h within %0d cycles", adr, BUS_GUARD);
			checks_bad++;
		end
		bus_cyc = 1'b0;	// Strobe drops in the ack cycle
		bus_stb = 1'b0;
		bus_we  = 1'b0;
	endtask

	task automatic write_bus(input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		logic [31:0] unused_rd;
		access_bus(1'b1, adr, sel, dat, unused_rd);
	endtask

	task automatic read_bus(input logic [31:0] adr, output logic [31:0] rdat);
		access_bus(1'b0, adr, 4'hf, '0, rdat);
	endtask

	// Region 3, bank in address bits 15..12, register in 11..2
	function automatic logic [31:0] csr_adr(input int bank, input soc_pkg::sysctl_reg_e idx);
		return 32'h3000_0000 | (32'(bank) << 12) | (32'(idx) << 2);
	endfunction

	task automatic write_csr(input soc_pkg::sysctl_reg_e idx, input logic [31:0] dat);
		write_bus(csr_adr(SYSCTL_BANK, idx), 4'hf, dat);
	endtask

	task automatic read_csr(input soc_pkg::sysctl_reg_e idx, output logic [31:0] rdat);
		read_bus(csr_adr(SYSCTL_BANK, idx), rdat);
	endtask

	task automatic store_model(input logic [IDX_W-1:0] idx, input logic [3:0] sel,
			input logic [31:0] dat);
		int b;
		for (b = 0; b < 4; b++) begin
			if (sel[b])
				ram_model[idx][8*b +: 8] = dat[8*b +: 8];	// Selected lanes only
		end
	endtask

	function automatic logic [31:0] fill_word(input int a);
		return 32'(a) * 32'h9e37_79b9 + 32'h1357_2468;	// Every address bit matters
	endfunction

	task automatic sweep_ram(input string name);
		int          i;
		logic [31:0] rd;
		for (i = 0; i < RAM_WORDS; i++) begin
			read_bus(32'(i) << 2, rd);
			compare_value(name, ram_model[IDX_W'(i)], rd);
		end
	endtask

	task automatic finish_test(input string name, input int bad_before);
		$display("Test %s finished with %0d errors", name, checks_bad - bad_before);
	endtask

	// Counts falling edges until irq_o is seen, limit + 1 if never
	task automatic wait_irq(input int limit, output int cycles);
		cycles = 0;
		while (!irq && cycles <= limit) begin
			@(negedge sys_clk);
			cycles++;
		end
	endtask

	// Falling edges while sys_rst_o stays high
	task automatic count_reset(output int cycles);
		cycles = 0;
		while (sys_rst && cycles < RESET_CYCLES + 16) begin
			@(negedge sys_clk);
			cycles++;
		end
	endtask

	task automatic test_ram();
		int          bad0;
		int          i;
		logic [31:0] word;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] rd;
		logic [3:0]  sel;
		bad0 = checks_bad;
		for (i = 0; i < RAM_WORDS; i++) begin
			write_bus(32'(i) << 2, 4'hf, fill_word(i));	// Defined base for byte writes
			ram_model[IDX_W'(i)] = fill_word(i);
		end
		for (i = 0; i < 200; i++) begin
			word = $urandom_range(4 * RAM_WORDS - 1, 0);	// Upper words alias
			adr  = (word << 2) | (32'($urandom_range(1, 0)) << 31);	// Bit 31 ignored
			dat  = $urandom();
			sel  = 4'($urandom());
			write_bus(adr, sel, dat);
			store_model(word[IDX_W-1:0], sel, dat);
			if ($urandom_range(1, 0) == 1) begin
				word = $urandom_range(4 * RAM_WORDS - 1, 0);
				read_bus(word << 2, rd);
				compare_value("ram read", ram_model[word[IDX_W-1:0]], rd);
			end
		end
		sweep_ram("ram sweep");
		finish_test("ram", bad0);
	endtask

	task automatic test_csr_gpio();
		int          bad0;
		int          i;
		int          region;
		logic [31:0] word;
		logic [31:0] dat;
		logic [31:0] rd;
		bad0 = checks_bad;
		read_csr(soc_pkg::REG_SYSTEM_ID, rd);
		compare_value("system id", soc_pkg::SYSTEM_ID, rd);
		for (i = 0; i < 4; i++) begin
			dat = $urandom();
			write_csr(soc_pkg::REG_GPIO_OUT, dat);
			compare_value("leds", 32'(dat[3:0]), 32'(leds));
			@(negedge sys_clk);
			gpio = 2'($urandom());
			repeat (4) @(negedge sys_clk);	// Two sync flops and the read register
			read_csr(soc_pkg::REG_GPIO_IN, rd);
			compare_value("gpio in", 32'(gpio), rd);
		end
		read_bus(csr_adr(SYSCTL_BANK + 1 + $urandom_range(13, 0), soc_pkg::REG_SYSTEM_ID), rd);
		compare_value("other bank", 32'd0, rd);
		for (i = 0; i < 4; i++) begin
			do
				region = $urandom_range(7, 1);
			while (region == 3);	// CSR region is mapped
			word = $urandom_range(RAM_WORDS - 1, 0);
			read_bus((32'(region) << 28) | (word << 2), rd);
			compare_value("unmapped read", 32'd0, rd);
			write_bus((32'(region) << 28) | (word << 2), 4'hf, ~ram_model[word[IDX_W-1:0]]);
			read_bus(word << 2, rd);
			compare_value("unmapped write", ram_model[word[IDX_W-1:0]], rd);
		end
		finish_test("csr_gpio", bad0);
	endtask

	task automatic test_timer_single();
		int          bad0;
		int          n;
		int          cycles;
		logic [31:0] rd;
		bad0 = checks_bad;
		n    = $urandom_range(60, 10);
		write_csr(soc_pkg::REG_TIMER_COMPARE, 32'(n));
		write_csr(soc_pkg::REG_TIMER_CTRL, 32'h1);	// Enable, no autoreload
		wait_irq(n + 8, cycles);
		compare_value("single irq window", 32'd1, 32'(cycles >= n && cycles <= n + 8));
		read_csr(soc_pkg::REG_TIMER_CTRL, rd);
		compare_value("single ctrl", 32'h4, rd);	// Expired only
		write_csr(soc_pkg::REG_TIMER_CTRL, 32'h4);
		compare_value("single irq clear", 32'd0, 32'(irq));
		finish_test("timer_single", bad0);
	endtask

	task automatic test_timer_autoreload();
		int          bad0;
		int          n;
		int          cycles;
		logic [31:0] rd;
		bad0 = checks_bad;
		n    = $urandom_range(60, 10);
		write_csr(soc_pkg::REG_TIMER_COMPARE, 32'(n));
		write_csr(soc_pkg::REG_TIMER_CTRL, 32'h3);
		wait_irq(n + 8, cycles);
		compare_value("reload irq window", 32'd1, 32'(cycles >= n && cycles <= n + 8));
		write_csr(soc_pkg::REG_TIMER_CTRL, 32'h7);	// Clear, keep running
		compare_value("reload irq clear", 32'd0, 32'(irq));
		wait_irq(n + 8, cycles);
		compare_value("reload irq again", 32'd1, 32'(irq));
		read_csr(soc_pkg::REG_TIMER_CTRL, rd);
		compare_value("reload enable kept", 32'h3, rd & 32'h3);
		write_csr(soc_pkg::REG_TIMER_CTRL, 32'h0);	// Stop first, then clear
		write_csr(soc_pkg::REG_TIMER_CTRL, 32'h4);
		compare_value("reload irq off", 32'd0, 32'(irq));
		finish_test("timer_autoreload", bad0);
	endtask

	task automatic test_pwm();
		int         bad0;
		int         i;
		int         k;
		int         high;
		logic [7:0] duty;
		bad0 = checks_bad;
		for (i = 0; i < 6; i++) begin
			duty = (i == 0) ? 8'd0 : (i == 1) ? 8'd255 : 8'($urandom());
			write_csr(soc_pkg::REG_PWM_DUTY, 32'(duty));
			repeat (4) @(negedge sys_clk);
			high = 0;
			for (k = 0; k < 256; k++) begin	// One full PWM period
				@(negedge sys_clk);
				if (pwm)
					high++;
			end
			compare_value("pwm duty", 32'(duty), 32'(high));
		end
		finish_test("pwm", bad0);
	endtask

	task automatic test_soft_reset();
		int          bad0;
		int          i;
		int          cycles;
		logic [31:0] word;
		logic [31:0] dat;
		logic [31:0] rd;
		bad0 = checks_bad;
		write_csr(soc_pkg::REG_GPIO_OUT, 32'($urandom_range(15, 1)));
		for (i = 0; i < 8; i++) begin
			word = $urandom_range(RAM_WORDS - 1, 0);
			dat  = $urandom();
			write_bus(word << 2, 4'hf, dat);
			store_model(word[IDX_W-1:0], 4'hf, dat);
		end
		write_csr(soc_pkg::REG_TIMER_COMPARE, 32'd30);
		write_csr(soc_pkg::REG_TIMER_CTRL, 32'h3);	// Count keeps running at reset
		wait_irq(38, cycles);
		compare_value("irq before reset", 32'd1, 32'(irq));
		write_csr(soc_pkg::REG_RESET, 32'h1);
		cycles = 0;
		while (!sys_rst && cycles < 8) begin
			@(negedge sys_clk);
			cycles++;
		end
		compare_value("soft reset rise", 32'd1, 32'(sys_rst));
		count_reset(cycles);
		compare_value("soft reset length", RESET_CYCLES, cycles);
		compare_value("leds after reset", 32'd0, 32'(leds));
		compare_value("irq after reset", 32'd0, 32'(irq));
		read_csr(soc_pkg::REG_TIMER_CTRL, rd);
		compare_value("ctrl after reset", 32'd0, rd);
		read_csr(soc_pkg::REG_TIMER_COMPARE, rd);
		compare_value("compare after reset", 32'd0, rd);
		read_csr(soc_pkg::REG_TIMER_COUNT, rd);
		compare_value("count after reset", 32'd0, rd);
		sweep_ram("ram kept");	// Array has no reset
		finish_test("soft_reset", bad0);
	endtask

	initial begin
		int cycles;
		void'($urandom(23));
		checks_ok  = 0;
		checks_bad = 0;
		hard_reset = 1'b1;
		bus_cyc    = 1'b0;
		bus_stb    = 1'b0;
		bus_we     = 1'b0;
		bus_adr    = '0;
		bus_sel    = '0;
		bus_dat_w  = '0;
		gpio       = '0;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		hard_reset = 1'b0;
		count_reset(cycles);
		compare_value("reset release", RESET_CYCLES, cycles);
		finish_test("reset", 0);
		test_ram();
		test_csr_gpio();
		test_timer_single();
		test_timer_autoreload();
		test_pwm();
		test_soft_reset();
		$display("Checks passed: %0d, checks failed: %0d", checks_ok, checks_bad);
		if (checks_bad == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- src.f
design/soc_pkg.sv
design/reset_seq.sv
design/bus_decode.sv
design/scratch_ram.sv
design/csr_bridge.sv
design/sysctl_regs.sv
design/sysctl_timer.sv
design/soc_top.sv
test/soc_props.sv
test/soc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the SoC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module soc_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vsoc_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All tests passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
